// File: hdl/filter_fmt_pkg.sv
package filter_fmt_pkg;

    // Input and output samples, Q1.13
    localparam int SAMPLE_W    = 14;
    localparam int SAMPLE_FRAC = 13;

    // Difference of two samples needs one extra integer bit
    localparam int DIFF_W = 15;

    // Coefficients, Q1.9
    localparam int COEFF_W    = 10;
    localparam int COEFF_FRAC = 9;

    // Rounded tap products and the accumulator share fraction length 16
    localparam int PROD_W   = 20;
    localparam int ACC_W    = 24;
    localparam int ACC_FRAC = 16;

    // Bits dropped by rounding: 22 -> 16 for a product, 16 -> 13 for the output
    localparam int PROD_SHIFT = SAMPLE_FRAC + COEFF_FRAC - ACC_FRAC;
    localparam int OUT_SHIFT  = ACC_FRAC - SAMPLE_FRAC;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [DIFF_W-1:0]   diff_t;
    typedef logic signed [COEFF_W-1:0]  coeff_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // One registered input sample with its strobe and mode level
    typedef struct packed {
        logic    valid;
        logic    mode;
        sample_t data;
    } sample_beat_t;

    // Mirrored samples feeding one antisymmetric tap
    typedef struct packed {
        sample_t near;
        sample_t far;
    } sample_pair_t;

endpackage

// File: hdl/filter_coeff_pkg.sv
package filter_coeff_pkg;

    // Five mirrored tap pairs over a ten-stage delay line
    localparam int NUM_TAPS    = 5;
    localparam int DELAY_DEPTH = 10;

    // Integrator mode feeds zeros into this stage and above
    localparam int ZERO_FILL_START = 6;

    // Feedback taps the accumulator of two valid samples earlier
    localparam int FEEDBACK_DELAY = 2;

    // Differentiator, units of 2^-9
    localparam filter_fmt_pkg::coeff_t DIFF_COEFFS [NUM_TAPS] = '{
        filter_fmt_pkg::coeff_t'(8),
        filter_fmt_pkg::coeff_t'(-26),
        filter_fmt_pkg::coeff_t'(60),
        filter_fmt_pkg::coeff_t'(-150),
        filter_fmt_pkg::coeff_t'(410)
    };

    // Simpson weights 1/6, 4/6, 1/6; pairs 3 and 4 unused
    localparam filter_fmt_pkg::coeff_t INTEG_COEFFS [NUM_TAPS] = '{
        filter_fmt_pkg::coeff_t'(85),
        filter_fmt_pkg::coeff_t'(341),
        filter_fmt_pkg::coeff_t'(85),
        filter_fmt_pkg::coeff_t'(0),
        filter_fmt_pkg::coeff_t'(0)
    };

endpackage

// File: hdl/tap_delay_line.sv
module tap_delay_line (
    input  logic                                                       clk,
    input  logic                                                       srst,
    input  logic                                                       mode,
    input  filter_fmt_pkg::sample_t                                    s_tdata,
    input  logic                                                       s_tvalid,
    output filter_fmt_pkg::sample_beat_t                               beat,
    output filter_fmt_pkg::sample_pair_t [filter_coeff_pkg::NUM_TAPS-1:0] pairs
);

    localparam int DEPTH = filter_coeff_pkg::DELAY_DEPTH;

    // Stage 0 holds the previous valid sample, stage DEPTH-1 the oldest
    filter_fmt_pkg::sample_t [DEPTH-1:0] stages;

    // Input register
    always_ff @(posedge clk) begin
        if (srst) begin
            beat <= '0;
        end else begin
            beat.valid <= s_tvalid;
            beat.mode  <= mode;
            beat.data  <= s_tdata;
        end
    end

    // Sample shift register, advances only on valid beats
    always_ff @(posedge clk) begin
        if (srst) begin
            stages <= '0;
        end else if (beat.valid) begin
            stages[0] <= beat.data;
            for (int i = 1; i < DEPTH; i++) begin
                // Integrator mode cuts the line short with zeros
                if (beat.mode && (i >= filter_coeff_pkg::ZERO_FILL_START)) begin
                    stages[i] <= '0;
                end else begin
                    stages[i] <= stages[i-1];
                end
            end
        end
    end

    // Mirrored pairs for the antisymmetric taps
    always_comb begin
        pairs[0].near = beat.data;
        pairs[0].far  = stages[DEPTH-1];
        for (int i = 1; i < filter_coeff_pkg::NUM_TAPS; i++) begin
            pairs[i].near = stages[i-1];
            pairs[i].far  = stages[DEPTH-1-i];
        end
    end

endmodule

// File: hdl/tap_product.sv
module tap_product #(
    parameter int TAP = 0
) (
    input  filter_fmt_pkg::sample_beat_t beat,
    input  filter_fmt_pkg::sample_pair_t pair,
    output filter_fmt_pkg::prod_t        product
);

    // Full precision product, fraction 22
    localparam int FULL_W = filter_fmt_pkg::DIFF_W + filter_fmt_pkg::COEFF_W;

    filter_fmt_pkg::diff_t   diff;
    filter_fmt_pkg::coeff_t  coeff;
    logic signed [FULL_W-1:0] full;

    // Antisymmetric difference, near minus far
    assign diff = filter_fmt_pkg::diff_t'($signed(pair.near))
                - filter_fmt_pkg::diff_t'($signed(pair.far));

    // Coefficient follows the registered mode
    assign coeff = beat.mode ? filter_coeff_pkg::INTEG_COEFFS[TAP]
                             : filter_coeff_pkg::DIFF_COEFFS[TAP];

    assign full = FULL_W'(diff) * FULL_W'(coeff);

    // Round half up, then keep the low PROD_W bits
    assign product = filter_fmt_pkg::prod_t'(full >>> filter_fmt_pkg::PROD_SHIFT)
                   + filter_fmt_pkg::prod_t'(full[filter_fmt_pkg::PROD_SHIFT-1]);

endmodule

// File: hdl/sum_feedback.sv
module sum_feedback (
    input  logic                                                 clk,
    input  logic                                                 srst,
    input  filter_fmt_pkg::sample_beat_t                         beat,
    input  filter_fmt_pkg::prod_t [filter_coeff_pkg::NUM_TAPS-1:0] products,
    output filter_fmt_pkg::sample_t                              m_tdata,
    output logic                                                 m_tvalid
);

    localparam int FB_DEPTH = filter_coeff_pkg::FEEDBACK_DELAY;

    filter_fmt_pkg::acc_t                acc_taps;
    filter_fmt_pkg::acc_t                fb_operand;
    filter_fmt_pkg::acc_t                acc_total;
    filter_fmt_pkg::acc_t [FB_DEPTH-1:0] fb_regs;
    filter_fmt_pkg::sample_t             rounded;

    // Adder chain over the taps
    // Products already carry ACC_FRAC, so only sign extension is needed
    always_comb begin
        acc_taps = '0;
        for (int i = 0; i < filter_coeff_pkg::NUM_TAPS; i++) begin
            acc_taps = acc_taps + filter_fmt_pkg::acc_t'(products[i]);
        end
    end

    // Recursive term only in integrator mode
    assign fb_operand = beat.mode ? fb_regs[FB_DEPTH-1] : '0;
    assign acc_total  = acc_taps + fb_operand;

    // Accumulator history, one step per valid beat
    always_ff @(posedge clk) begin
        if (srst) begin
            fb_regs <= '0;
        end else if (beat.valid) begin
            fb_regs[0] <= acc_total;
            for (int i = 1; i < FB_DEPTH; i++) begin
                fb_regs[i] <= fb_regs[i-1];
            end
        end
    end

    // Round half up to the output format, wraparound on overflow
    assign rounded = filter_fmt_pkg::sample_t'(acc_total >>> filter_fmt_pkg::OUT_SHIFT)
                   + filter_fmt_pkg::sample_t'(acc_total[filter_fmt_pkg::OUT_SHIFT-1]);

    // Output register holds between valid beats
    always_ff @(posedge clk) begin
        if (srst) begin
            m_tdata <= '0;
        end else if (beat.valid) begin
            m_tdata <= rounded;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            m_tvalid <= 1'b0;
        end else begin
            m_tvalid <= beat.valid;
        end
    end

endmodule

// File: hdl/adaptive_filter.sv
module adaptive_filter (
    input  logic                    clk,
    input  logic                    srst,
    input  logic                    mode,
    input  filter_fmt_pkg::sample_t s_tdata,
    input  logic                    s_tvalid,
    output filter_fmt_pkg::sample_t m_tdata,
    output logic                    m_tvalid
);

    // Registered input beat shared by all stages
    filter_fmt_pkg::sample_beat_t                                beat;
    filter_fmt_pkg::sample_pair_t [filter_coeff_pkg::NUM_TAPS-1:0] pairs;
    filter_fmt_pkg::prod_t        [filter_coeff_pkg::NUM_TAPS-1:0] products;

    tap_delay_line delay_line_i (
        .clk      (clk),
        .srst     (srst),
        .mode     (mode),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .beat     (beat),
        .pairs    (pairs)
    );

    // One multiplier per mirrored pair
    for (genvar i = 0; i < filter_coeff_pkg::NUM_TAPS; i++) begin : g_tap
        tap_product #(
            .TAP (i)
        ) tap_i (
            .beat    (beat),
            .pair    (pairs[i]),
            .product (products[i])
        );
    end

    sum_feedback sum_i (
        .clk      (clk),
        .srst     (srst),
        .beat     (beat),
        .products (products),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid)
    );

endmodule

// File: verif/adaptive_filter_assert.sv
module adaptive_filter_assert (
    input logic                    clk,
    input logic                    srst,
    input logic                    s_tvalid,
    input logic                    m_tvalid,
    input filter_fmt_pkg::sample_t m_tdata
);

    // Reset seen on the last two edges
    logic [1:0] srst_hist = 2'b11;

    // Failed assertions, read by the testbench at the end of the run
    int failure_count = 0;

    always @(posedge clk) begin
        srst_hist <= {srst_hist[0], srst};
    end

    // Two-edge latency with one output pulse per input pulse
    a_latency : assert property (
        @(posedge clk) disable iff (srst || (|srst_hist))
        m_tvalid == $past(s_tvalid, 2)
    ) else begin
        failure_count++;
        $error("m_tvalid does not follow s_tvalid by exactly two cycles");
    end

    a_reset_low : assert property (
        @(posedge clk) $past(srst) |-> !m_tvalid
    ) else begin
        failure_count++;
        $error("m_tvalid is high right after reset");
    end

    // Output data only moves together with the strobe
    a_hold : assert property (
        @(posedge clk) disable iff (srst || srst_hist[0])
        !m_tvalid |-> $stable(m_tdata)
    ) else begin
        failure_count++;
        $error("m_tdata changed while m_tvalid was low");
    end

endmodule

// File: verif/filter_checker.sv
module filter_checker (
    input  logic                    clk,
    input  logic                    srst,
    input  logic                    mode,
    input  filter_fmt_pkg::sample_t s_tdata,
    input  logic                    s_tvalid,
    input  filter_fmt_pkg::sample_t m_tdata,
    input  logic                    m_tvalid,
    input  logic                    end_run,
    output int                      mismatch_count,
    output int                      stray_count,
    output int                      missing_count,
    output int                      pending
);

    localparam int DEPTH    = filter_coeff_pkg::DELAY_DEPTH;
    localparam int TAPS     = filter_coeff_pkg::NUM_TAPS;
    localparam int FB_DEPTH = filter_coeff_pkg::FEEDBACK_DELAY;

    // Reference state, kept as plain integers
    longint                  model_stages [DEPTH];
    longint                  model_acc    [FB_DEPTH];
    filter_fmt_pkg::sample_t expected_q   [$];
    logic                    reset_seen;
    logic                    end_done;

    // Low width bits read back as a two's complement value
    function automatic longint wrap_to(input longint value, input int width);
        longint span;
        longint low;
        span = longint'(1) << width;
        low  = value & (span - 1);
        if (low >= (span >> 1)) begin
            low = low - span;
        end
        return low;
    endfunction

    // Round half up, same as adding the top dropped bit after the shift
    function automatic longint round_off(input longint value, input int shift);
        return (value + (longint'(1) << (shift - 1))) >>> shift;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < DEPTH; i++) begin
            model_stages[i] = 0;
        end
        for (int i = 0; i < FB_DEPTH; i++) begin
            model_acc[i] = 0;
        end
        expected_q.delete();
    endtask

    // One valid input sample through the reference filter
    task automatic model_beat(input logic beat_mode, input longint data);
        longint near;
        longint far;
        longint coeff;
        longint prod;
        longint acc;
        acc = 0;
        for (int i = 0; i < TAPS; i++) begin
            if (i == 0) begin
                near = data;
            end else begin
                near = model_stages[i-1];
            end
            far = model_stages[DEPTH-1-i];
            if (beat_mode) begin
                coeff = longint'(filter_coeff_pkg::INTEG_COEFFS[i]);
            end else begin
                coeff = longint'(filter_coeff_pkg::DIFF_COEFFS[i]);
            end
            prod = wrap_to(round_off((near - far) * coeff, filter_fmt_pkg::PROD_SHIFT),
                           filter_fmt_pkg::PROD_W);
            acc  = wrap_to(acc + prod, filter_fmt_pkg::ACC_W);
        end
        if (beat_mode) begin
            acc = wrap_to(acc + model_acc[FB_DEPTH-1], filter_fmt_pkg::ACC_W);
        end
        expected_q.push_back(filter_fmt_pkg::sample_t'(
            wrap_to(round_off(acc, filter_fmt_pkg::OUT_SHIFT), filter_fmt_pkg::SAMPLE_W)));

        // Shift from the far end so no stage is overwritten early
        for (int i = DEPTH - 1; i > 0; i--) begin
            if (beat_mode && (i >= filter_coeff_pkg::ZERO_FILL_START)) begin
                model_stages[i] = 0;
            end else begin
                model_stages[i] = model_stages[i-1];
            end
        end
        model_stages[0] = data;
        for (int i = FB_DEPTH - 1; i > 0; i--) begin
            model_acc[i] = model_acc[i-1];
        end
        model_acc[0] = acc;
    endtask

    initial begin
        mismatch_count = 0;
        stray_count    = 0;
        missing_count  = 0;
        pending        = 0;
        reset_seen     = 1'b0;
        end_done       = 1'b0;
        clear_model();
    end

    always @(posedge clk) begin
        filter_fmt_pkg::sample_t want;
        // Outputs at this edge belong to beats of earlier edges
        if (m_tvalid === 1'b1) begin
            if (expected_q.size() == 0) begin
                stray_count++;
                $display("At time %0t the DUT gave an output that no input sample explains",
                         $time);
            end else begin
                want = expected_q.pop_front();
                if (m_tdata !== want) begin
                    mismatch_count++;
                    $display("FAIL %0t: m_tdata %0d, expected %0d", $time, m_tdata, want);
                end
            end
        end

        // First edge out of reset shows the cleared output register
        if (reset_seen && !srst) begin
            if ((m_tvalid !== 1'b0) || (m_tdata !== '0)) begin
                mismatch_count++;
                $display("FAIL %0t: after reset m_tvalid %0b m_tdata %0d, expected 0 and 0",
                         $time, m_tvalid, m_tdata);
            end
        end

        if (srst) begin
            clear_model();
            reset_seen = 1'b1;
        end else begin
            reset_seen = 1'b0;
            if (s_tvalid) begin
                model_beat(mode, longint'(s_tdata));
            end
        end

        if (end_run && !end_done) begin
            end_done = 1'b1;
            if (expected_q.size() != 0) begin
                missing_count += expected_q.size();
                $display("%0d expected outputs never appeared at the end of the run",
                         expected_q.size());
            end
        end
        pending = expected_q.size();
    end

endmodule

// File: verif/tb_adaptive_filter.sv
module tb_adaptive_filter;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_LIMIT  = 20;

    // Row kinds
    localparam logic [1:0] ROW_FIXED  = 2'd0;
    localparam logic [1:0] ROW_RANDOM = 2'd1;
    localparam logic [1:0] ROW_RESET  = 2'd2;

    // Idle value that asks for a random gap of 0 to 5 cycles
    localparam logic [3:0] GAP_RANDOM = 4'hf;

    // One table row where count repeats the sample or holds reset that long
    typedef struct packed {
        logic [1:0]              kind;
        logic                    mode;
        filter_fmt_pkg::sample_t sample;
        logic [9:0]              count;
        logic [3:0]              idle;
    } stim_row_t;

    localparam int NUM_ROWS = 17;

    localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
        // Positive and then negative differentiator impulse
        '{ROW_FIXED,  1'b0,  14'sd4096, 10'd1,   4'd0},
        '{ROW_FIXED,  1'b0,  14'sd0,    10'd12,  4'd0},
        '{ROW_FIXED,  1'b0, -14'sd6000, 10'd1,   4'd2},
        '{ROW_FIXED,  1'b0,  14'sd0,    10'd12,  4'd1},
        // Integrator step long enough for the accumulator to wrap
        '{ROW_FIXED,  1'b1,  14'sd8000, 10'd300, 4'd0},
        '{ROW_FIXED,  1'b1, -14'sd3000, 10'd24,  4'd0},
        // Random gaps in both modes
        '{ROW_RANDOM, 1'b0,  14'sd0,    10'd24,  GAP_RANDOM},
        '{ROW_RANDOM, 1'b1,  14'sd0,    10'd24,  GAP_RANDOM},
        // Mode switches mid-stream
        '{ROW_RANDOM, 1'b0,  14'sd0,    10'd12,  4'd0},
        '{ROW_RANDOM, 1'b1,  14'sd0,    10'd4,   4'd0},
        '{ROW_RANDOM, 1'b0,  14'sd0,    10'd6,   4'd1},
        '{ROW_RANDOM, 1'b1,  14'sd0,    10'd3,   4'd0},
        '{ROW_RANDOM, 1'b0,  14'sd0,    10'd12,  4'd0},
        // Reset with samples in flight and a fresh start after it
        '{ROW_RANDOM, 1'b1,  14'sd0,    10'd5,   4'd0},
        '{ROW_RESET,  1'b0,  14'sd0,    10'd3,   4'd0},
        '{ROW_FIXED,  1'b0,  14'sd4096, 10'd1,   4'd0},
        '{ROW_RANDOM, 1'b0,  14'sd0,    10'd16,  4'd0}
    };

    logic                    clk = 1'b0;
    logic                    srst;
    logic                    mode;
    filter_fmt_pkg::sample_t s_tdata;
    logic                    s_tvalid;
    filter_fmt_pkg::sample_t m_tdata;
    logic                    m_tvalid;
    logic                    end_run;

    int mismatch_count;
    int stray_count;
    int missing_count;
    int pending;
    int timeout_count;

    always #CLK_HALF clk = ~clk;

    adaptive_filter dut_i (
        .clk      (clk),
        .srst     (srst),
        .mode     (mode),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid)
    );

    filter_checker checker_i (
        .clk            (clk),
        .srst           (srst),
        .mode           (mode),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .m_tdata        (m_tdata),
        .m_tvalid       (m_tvalid),
        .end_run        (end_run),
        .mismatch_count (mismatch_count),
        .stray_count    (stray_count),
        .missing_count  (missing_count),
        .pending        (pending)
    );

    bind adaptive_filter adaptive_filter_assert assert_i (
        .clk      (clk),
        .srst     (srst),
        .s_tvalid (s_tvalid),
        .m_tvalid (m_tvalid),
        .m_tdata  (m_tdata)
    );

    // One-cycle strobe driven on the falling edge
    task automatic send_sample(input logic beat_mode, input filter_fmt_pkg::sample_t data);
        mode     = beat_mode;
        s_tdata  = data;
        s_tvalid = 1'b1;
        @(negedge clk);
        s_tvalid = 1'b0;
    endtask

    task automatic apply_row(input stim_row_t row);
        int                      gap;
        filter_fmt_pkg::sample_t data;
        if (row.kind == ROW_RESET) begin
            srst     = 1'b1;
            s_tvalid = 1'b0;
            repeat (int'(row.count)) @(negedge clk);
            srst = 1'b0;
        end else begin
            for (int n = 0; n < int'(row.count); n++) begin
                if (row.kind == ROW_RANDOM) begin
                    data = filter_fmt_pkg::sample_t'($urandom());
                end else begin
                    data = row.sample;
                end
                if (row.idle == GAP_RANDOM) begin
                    gap = int'($urandom_range(5, 0));
                end else begin
                    gap = int'(row.idle);
                end
                send_sample(row.mode, data);
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    // Let the last samples come out within a bounded wait
    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while ((pending != 0) && (cycles < DRAIN_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            timeout_count++;
            $display("Timeout: %0d outputs still outstanding after %0d cycles",
                     pending, DRAIN_LIMIT);
        end
    endtask

    initial begin
        int total;
        int assert_count;
        srst          = 1'b1;
        mode          = 1'b0;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        end_run       = 1'b0;
        timeout_count = 0;
        void'($urandom(32'h1bff));

        repeat (RESET_CYCLES) @(negedge clk);
        srst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(STIM_TABLE[r]);
        end

        wait_for_drain();
        end_run = 1'b1;
        @(negedge clk);
        @(negedge clk);

        assert_count = dut_i.assert_i.failure_count;
        total = mismatch_count + stray_count + missing_count + timeout_count + assert_count;
        $display("Errors: mismatch %0d, stray %0d, missing %0d, timeout %0d, assertion %0d",
                 mismatch_count, stray_count, missing_count, timeout_count, assert_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/filter_fmt_pkg.sv
hdl/filter_coeff_pkg.sv
hdl/tap_delay_line.sv
hdl/tap_product.sv
hdl/sum_feedback.sv
hdl/adaptive_filter.sv
verif/adaptive_filter_assert.sv
verif/filter_checker.sv
verif/tb_adaptive_filter.sv

// File: Makefile
# Verilator simulation of the adaptive filter
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_adaptive_filter
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
